// ==== project.f ====
+incdir+testbench
verilog/divsqrt_pkg.sv
verilog/divsqrt_if.sv
verilog/divsqrt_issue_stage.sv
verilog/divsqrt_datapath.sv
verilog/divsqrt_ctrl.sv
verilog/divsqrt_out_stage.sv
verilog/divsqrt_top.sv
testbench/tb_divsqrt.sv

// ==== Makefile ====
# Verilator build and run of the divide and square-root testbench

VERILATOR ?= verilator
TOP       ?= tb_divsqrt
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Done: no errors
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# The pass message in the log decides the result, not the exit code of the model
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/tb_divsqrt_tasks.svh ====
// Included inside tb_divsqrt; relies on its DUT signals, exp_q, lcg_state and TIMEOUT

// ----------------------------------------
// Helpers
// ----------------------------------------
function automatic logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

task automatic abort_run(input string why);
  $display("%s", why);
  $display("Done: errors found");
  $fatal(1, "stopped at first error");
endtask

task automatic check_operand(input string name, input divsqrt_pkg::operand_t got,
                             input divsqrt_pkg::operand_t exp);
  if (got !== exp) begin
    abort_run($sformatf("Fail: %s got %h expected %h", name, got, exp));
  end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    abort_run($sformatf("Fail: %s got %h expected %h", name, got, exp));
  end
endtask

task automatic check_tag(input string name, input divsqrt_pkg::tag_t got,
                         input divsqrt_pkg::tag_t exp);
  if (got !== exp) begin
    abort_run($sformatf("Fail: %s got %h expected %h", name, got, exp));
  end
endtask

// Reference model built from the result rules
function automatic exp_t model(input divsqrt_pkg::op_e op, input divsqrt_pkg::operand_t a,
                               input divsqrt_pkg::operand_t b, input divsqrt_pkg::tag_t tag);
  exp_t                  e;
  divsqrt_pkg::operand_t r;
  divsqrt_pkg::operand_t t;
  int                    i;
  e.tag = tag;
  e.dz  = 1'b0;
  if (op == divsqrt_pkg::OP_DIV) begin
    if (b == '0) begin
      e.dz     = 1'b1;
      e.result = '1;  // All-ones quotient
      e.rem    = a;
    end else begin
      e.result = a / b;
      e.rem    = a % b;
    end
  end else begin
    r = '0;
    // Keep each root bit whose square still fits under a
    for (i = 15; i >= 0; i--) begin
      t = r | (divsqrt_pkg::operand_t'(1) << i);
      if (t * t <= a) r = t;  // Square stays within 32 bits
    end
    e.result = r;
    e.rem    = a - r * r;
  end
  return e;
endfunction

// ----------------------------------------
// Drive and receive
// ----------------------------------------
task automatic drive_op(input divsqrt_pkg::op_e op, input divsqrt_pkg::operand_t a,
                        input divsqrt_pkg::operand_t b, input divsqrt_pkg::tag_t tag);
  int unsigned wait_cnt;
  wait_cnt = 0;
  @(posedge clk_i);
  in_valid_i <= 1'b1;
  in_op_i    <= op;
  in_opa_i   <= a;
  in_opb_i   <= b;
  in_tag_i   <= tag;
  @(negedge clk_i);
  while (!in_ready_o) begin  // Ready does not depend on valid
    if (wait_cnt == TIMEOUT) abort_run("in_ready_o stayed low, request never accepted");
    wait_cnt++;
    @(negedge clk_i);
  end
  @(posedge clk_i);  // Transfer edge
  in_valid_i <= 1'b0;
endtask

task automatic issue_op(input divsqrt_pkg::op_e op, input divsqrt_pkg::operand_t a,
                        input divsqrt_pkg::operand_t b, input divsqrt_pkg::tag_t tag);
  exp_q.push_back(model(op, a, b, tag));
  drive_op(op, a, b, tag);
endtask

// Takes n results in order with optional random back-pressure
task automatic recv_check(input int unsigned n, input bit rand_ready);
  int unsigned wait_cnt;
  int unsigned i;
  exp_t        e;
  logic        ready_nxt;  // Next out_ready_i value from the falling edge
  ready_nxt = 1'b1;
  for (i = 0; i < n; i++) begin
    wait_cnt = 0;
    do begin
      if (wait_cnt == TIMEOUT) abort_run("out_valid_o never rose for an expected result");
      wait_cnt++;
      @(posedge clk_i);
      out_ready_i <= ready_nxt;
      @(negedge clk_i);
      if (rand_ready) ready_nxt = (lcg_next() % 32'd3) != 32'd0;
    end while (!(out_valid_o && out_ready_i));
    if (exp_q.size() == 0) abort_run("result seen with no operation outstanding");
    e = exp_q.pop_front();
    check_operand("out_result_o", out_result_o, e.result);
    check_operand("out_rem_o", out_rem_o, e.rem);
    check_flag("out_dz_o", out_dz_o, e.dz);
    check_tag("out_tag_o", out_tag_o, e.tag);
  end
  @(posedge clk_i);  // Last acceptance
endtask

// ----------------------------------------
// Directed tests
// ----------------------------------------
task automatic reset_test();
  @(negedge clk_i);
  check_flag("out_valid_o", out_valid_o, 1'b0);
  check_flag("busy_o", busy_o, 1'b0);
  check_flag("in_ready_o", in_ready_o, 1'b1);
endtask

task automatic div_test();
  issue_op(divsqrt_pkg::OP_DIV, 32'd100, 32'd7, 4'h1);
  recv_check(1, 1'b0);
  issue_op(divsqrt_pkg::OP_DIV, 32'd7, 32'd100, 4'h2);  // Quotient 0
  recv_check(1, 1'b0);
  issue_op(divsqrt_pkg::OP_DIV, '1, '1, 4'h3);
  recv_check(1, 1'b0);
  issue_op(divsqrt_pkg::OP_DIV, '1, 32'd1, 4'h4);
  recv_check(1, 1'b0);
  issue_op(divsqrt_pkg::OP_DIV, 32'h12345678, '0, 4'h5);  // Divide by zero
  recv_check(1, 1'b0);
endtask

task automatic sqrt_test();
  issue_op(divsqrt_pkg::OP_SQRT, 32'd0, 32'd9, 4'h6);
  recv_check(1, 1'b0);
  issue_op(divsqrt_pkg::OP_SQRT, 32'd1, '0, 4'h7);  // opb ignored
  recv_check(1, 1'b0);
  issue_op(divsqrt_pkg::OP_SQRT, 32'd144, '0, 4'h8);
  recv_check(1, 1'b0);
  issue_op(divsqrt_pkg::OP_SQRT, 32'd1000, '0, 4'h9);
  recv_check(1, 1'b0);
  issue_op(divsqrt_pkg::OP_SQRT, '1, '0, 4'ha);
  recv_check(1, 1'b0);
endtask

// Three in flight behind a stalled output while the first result holds still
task automatic backpressure_test();
  exp_t snap;
  int   i;
  @(posedge clk_i);
  out_ready_i <= 1'b0;
  issue_op(divsqrt_pkg::OP_DIV, 32'hdeadbeef, 32'd13, 4'hb);
  issue_op(divsqrt_pkg::OP_SQRT, 32'h00fedcba, '0, 4'hc);
  issue_op(divsqrt_pkg::OP_DIV, 32'd5, 32'd3, 4'hd);
  @(negedge clk_i);
  check_flag("out_valid_o", out_valid_o, 1'b1);  // First result long done by now
  snap = '{out_result_o, out_rem_o, out_dz_o, out_tag_o};
  for (i = 0; i < 40; i++) begin
    @(negedge clk_i);
    check_flag("out_valid_o", out_valid_o, 1'b1);
    check_operand("out_result_o", out_result_o, snap.result);
    check_operand("out_rem_o", out_rem_o, snap.rem);
    check_flag("out_dz_o", out_dz_o, snap.dz);
    check_tag("out_tag_o", out_tag_o, snap.tag);
  end
  recv_check(3, 1'b0);
  @(negedge clk_i);
  check_flag("busy_o", busy_o, 1'b0);
endtask

task automatic flush_test();
  int i;
  drive_op(divsqrt_pkg::OP_DIV, 32'hcafef00d, 32'd3, 4'he);  // Cancelled by the flush below
  repeat (5) @(posedge clk_i);
  flush_i <= 1'b1;
  @(posedge clk_i);
  flush_i <= 1'b0;
  for (i = 0; i < 45; i++) begin  // Past the point where the divide would finish
    @(negedge clk_i);
    check_flag("out_valid_o", out_valid_o, 1'b0);
    check_flag("busy_o", busy_o, 1'b0);
  end
  issue_op(divsqrt_pkg::OP_SQRT, 32'd99, '0, 4'hf);
  recv_check(1, 1'b0);
endtask

// ----------------------------------------
// Random mix
// ----------------------------------------
task automatic random_test(input int unsigned n);
  fork
    begin : sender
      int unsigned           k;
      divsqrt_pkg::op_e      op;
      divsqrt_pkg::operand_t a;
      divsqrt_pkg::operand_t b;
      logic [31:0]           sh;
      for (k = 0; k < n; k++) begin
        op = ((lcg_next() >> 31) != 0) ? divsqrt_pkg::OP_SQRT : divsqrt_pkg::OP_DIV;
        a  = lcg_next();
        sh = lcg_next() & 32'd31;
        b  = lcg_next() >> sh;  // Spread of divisor sizes with an occasional zero
        issue_op(op, a, b, divsqrt_pkg::tag_t'(k));
      end
    end
    recv_check(n, 1'b1);
  join
endtask

// ==== testbench/tb_divsqrt.sv ====
// Runs directed and random checks in one pass and stops at the first mismatch or timeout
`timescale 1ns/1ps

module tb_divsqrt;

  localparam int unsigned TIMEOUT = 500;  // Cycles any single wait may take

  // Expected response of one operation
  typedef struct packed {
    divsqrt_pkg::operand_t result;
    divsqrt_pkg::operand_t rem;
    logic                  dz;
    divsqrt_pkg::tag_t     tag;
  } exp_t;

  // ----------------------------------------
  // DUT signals
  // ----------------------------------------
  logic                  clk_i;
  logic                  rst_n_i;
  logic                  in_valid_i;
  logic                  in_ready_o;
  divsqrt_pkg::op_e      in_op_i;
  divsqrt_pkg::operand_t in_opa_i;
  divsqrt_pkg::operand_t in_opb_i;
  divsqrt_pkg::tag_t     in_tag_i;
  logic                  out_valid_o;
  logic                  out_ready_i;
  divsqrt_pkg::operand_t out_result_o;
  divsqrt_pkg::operand_t out_rem_o;
  logic                  out_dz_o;
  divsqrt_pkg::tag_t     out_tag_o;
  logic                  flush_i;
  logic                  busy_o;

  exp_t        exp_q[$];   // Results still owed by the DUT, in issue order
  logic [31:0] lcg_state;  // Random generator state

  always #4 clk_i = ~clk_i;  // 8 ns period

  divsqrt_top dut_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .in_valid_i   (in_valid_i),
    .in_ready_o   (in_ready_o),
    .in_op_i      (in_op_i),
    .in_opa_i     (in_opa_i),
    .in_opb_i     (in_opb_i),
    .in_tag_i     (in_tag_i),
    .out_valid_o  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .out_result_o (out_result_o),
    .out_rem_o    (out_rem_o),
    .out_dz_o     (out_dz_o),
    .out_tag_o    (out_tag_o),
    .flush_i      (flush_i),
    .busy_o       (busy_o)
  );

  `include "tb_divsqrt_tasks.svh"

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    clk_i       = 1'b0;
    rst_n_i     = 1'b0;  // Held low for five edges
    in_valid_i  = 1'b0;
    in_op_i     = divsqrt_pkg::OP_DIV;
    in_opa_i    = '0;
    in_opb_i    = '0;
    in_tag_i    = '0;
    out_ready_i = 1'b1;
    flush_i     = 1'b0;
    lcg_state   = 32'he32e5f17;
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
    reset_test();
    div_test();
    sqrt_test();
    backpressure_test();
    flush_test();
    random_test(200);
    $display("Done: no errors");
    $finish;
  end

endmodule

// ==== verilog/divsqrt_top.sv ====
// Issue register, iterative engine and output register; up to three operations in flight
`timescale 1ns/1ps

module divsqrt_top (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  // Request side
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  input  divsqrt_pkg::op_e      in_op_i,
  input  divsqrt_pkg::operand_t in_opa_i,
  input  divsqrt_pkg::operand_t in_opb_i,
  input  divsqrt_pkg::tag_t     in_tag_i,
  // Result side
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output divsqrt_pkg::operand_t out_result_o,
  output divsqrt_pkg::operand_t out_rem_o,
  output logic                  out_dz_o,
  output divsqrt_pkg::tag_t     out_tag_o,
  // Control and status
  input  logic                  flush_i,
  output logic                  busy_o
);

  op_if  op_bus ();
  res_if res_bus ();

  logic issue_busy, ctrl_busy, out_busy;
  logic load, done;  // Engine start and finish pulses

  // ----------------------------------------
  // Chain
  // ----------------------------------------
  divsqrt_issue_stage u_issue (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .in_valid_i (in_valid_i),
    .in_ready_o (in_ready_o),
    .in_op_i    (in_op_i),
    .in_opa_i   (in_opa_i),
    .in_opb_i   (in_opb_i),
    .in_tag_i   (in_tag_i),
    .flush_i    (flush_i),
    .op         (op_bus.producer),
    .busy_o     (issue_busy)
  );

  divsqrt_ctrl u_ctrl (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .flush_i (flush_i),
    .op      (op_bus.consumer),
    .res     (res_bus.producer_ctl),
    .load_o  (load),
    .done_i  (done),
    .busy_o  (ctrl_busy)
  );

  // Operands come straight off the issue register, latched on load
  divsqrt_datapath u_dp (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .load_i  (load),
    .op_i    (op_bus.op),
    .opa_i   (op_bus.opa),
    .opb_i   (op_bus.opb),
    .done_o  (done),
    .res     (res_bus.producer_dp)
  );

  divsqrt_out_stage u_out (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .res          (res_bus.consumer),
    .out_valid_o  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .out_result_o (out_result_o),
    .out_rem_o    (out_rem_o),
    .out_dz_o     (out_dz_o),
    .out_tag_o    (out_tag_o),
    .busy_o       (out_busy)
  );

  assign busy_o = issue_busy | ctrl_busy | out_busy;  // Valid data anywhere

endmodule

// ==== verilog/divsqrt_out_stage.sv ====
// Single output register; flush drops the held result even while it is stalled
`timescale 1ns/1ps

module divsqrt_out_stage (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   flush_i,
  res_if.consumer                res,
  output logic                   out_valid_o,
  input  logic                   out_ready_i,
  output divsqrt_pkg::operand_t  out_result_o,
  output divsqrt_pkg::operand_t  out_rem_o,
  output logic                   out_dz_o,
  output divsqrt_pkg::tag_t      out_tag_o,
  output logic                   busy_o
);

  logic valid_q;
  logic reg_en;

  assign res.ready = ~valid_q | out_ready_i;  // Empty or draining
  assign reg_en    = res.valid & res.ready;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (res.ready) begin
      valid_q <= res.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reg_en) begin
      out_result_o <= res.result;
      out_rem_o    <= res.rem;
      out_dz_o     <= res.dz;
      out_tag_o    <= res.tag;
    end
  end

  assign out_valid_o = valid_q;
  assign busy_o      = valid_q;

  // Downstream sees a steady result until it takes it
  a_out_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i && !flush_i |=>
      out_valid_o && $stable({out_result_o, out_rem_o, out_dz_o, out_tag_o}));

endmodule

// ==== verilog/divsqrt_ctrl.sv ====
// Takes one operation at a time and only in IDLE; a done that comes in IDLE is dropped
`timescale 1ns/1ps

module divsqrt_ctrl (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        flush_i,
  op_if.consumer      op,
  res_if.producer_ctl res,
  output logic        load_o,  // Start the datapath
  input  logic        done_i,  // Datapath result ready
  output logic        busy_o
);

  typedef enum logic [1:0] {
    IDLE,  // Waiting for an operation
    BUSY,  // Datapath iterating
    HOLD   // Result waiting for the output stage
  } ctrl_state_e;

  ctrl_state_e       state_q, state_d;
  divsqrt_pkg::tag_t tag_q;

  // ----------------------------------------
  // Acceptance
  // ----------------------------------------
  assign op.ready = (state_q == IDLE);
  assign load_o   = op.valid & op.ready & ~flush_i;  // No start while flushing

  // Tag follows the operation through the datapath
  always_ff @(posedge clk_i) begin
    if (load_o) tag_q <= op.tag;
  end

  assign res.tag = tag_q;

  // ----------------------------------------
  // FSM
  // ----------------------------------------
  always_comb begin
    state_d   = state_q;
    res.valid = 1'b0;
    unique case (state_q)
      IDLE: begin
        if (load_o) state_d = BUSY;
      end
      BUSY: begin
        if (done_i) begin
          res.valid = 1'b1;                  // Offer straight from datapath
          state_d   = res.ready ? IDLE : HOLD;
        end
      end
      HOLD: begin
        res.valid = 1'b1;  // Datapath keeps the payload
        if (res.ready) state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
    // Flush beats everything
    if (flush_i) begin
      res.valid = 1'b0;
      state_d   = IDLE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) state_q <= IDLE;
    else          state_q <= state_d;
  end

  assign busy_o = (state_q != IDLE);

  // A restart clears any done still pending in the datapath
  a_load_restart: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    load_o |=> !done_i);

  // Results only after at least one busy cycle
  a_valid_not_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(res.valid) |-> (state_q != IDLE) && ($past(state_q) != IDLE));

endmodule

// ==== verilog/divsqrt_datapath.sv ====
// Unsigned 32-bit restoring divide and 16-step integer square root; results hold until next load
`timescale 1ns/1ps

module divsqrt_datapath (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  load_i,   // Start pulse from ctrl
  input  divsqrt_pkg::op_e      op_i,
  input  divsqrt_pkg::operand_t opa_i,
  input  divsqrt_pkg::operand_t opb_i,
  output logic                  done_o,   // Results valid, one-cycle pulse
  res_if.producer_dp            res
);

  localparam int unsigned OW = divsqrt_pkg::OPERAND_W;

  typedef logic [$clog2(divsqrt_pkg::DIV_STEPS+1)-1:0] step_cnt_t;

  // Load cycle does the first step, so count the rest
  localparam step_cnt_t DIV_LAST  = step_cnt_t'(divsqrt_pkg::DIV_STEPS - 1);
  localparam step_cnt_t SQRT_LAST = step_cnt_t'(divsqrt_pkg::SQRT_STEPS - 1);

  // ----------------------------------------
  // State
  // ----------------------------------------
  step_cnt_t             cnt_q;   // Steps still to run
  logic                  done_q;
  divsqrt_pkg::op_e      op_q;
  divsqrt_pkg::operand_t dvs_q;   // Divisor
  divsqrt_pkg::operand_t sh_q;    // Dividend or radicand, shifted out from the top
  divsqrt_pkg::operand_t acc_q;   // Partial remainder
  divsqrt_pkg::operand_t res_q;   // Quotient or root, shifted in at the bottom
  logic                  dz_q;

  // Step inputs, taken straight from the ports on load
  divsqrt_pkg::op_e      cur_op;
  divsqrt_pkg::operand_t cur_sh, cur_acc, cur_res, cur_dvs;
  logic [OW:0]           r_shift;  // Remainder with next bits appended
  logic [OW:0]           subtr;    // Divisor, or trial root 4q+1
  logic [OW+1:0]         diff;
  logic                  bit_ok;   // Trial subtraction did not go negative
  logic                  step_en;

  // ----------------------------------------
  // One restoring step
  // ----------------------------------------
  always_comb begin
    cur_op  = load_i ? op_i  : op_q;
    cur_sh  = load_i ? opa_i : sh_q;
    cur_acc = load_i ? '0    : acc_q;
    cur_res = load_i ? '0    : res_q;
    cur_dvs = load_i ? opb_i : dvs_q;
    if (cur_op == divsqrt_pkg::OP_DIV) begin
      r_shift = {cur_acc, cur_sh[OW-1]};      // Bring down one dividend bit
      subtr   = {1'b0, cur_dvs};
    end else begin
      r_shift = {cur_acc[OW-2:0], cur_sh[OW-1:OW-2]};  // Next digit pair
      subtr   = {cur_res[OW-2:0], 2'b01};
    end
    diff   = {1'b0, r_shift} - {1'b0, subtr};
    bit_ok = ~diff[OW+1];
  end

  assign step_en = load_i | (cnt_q != '0);

  // Zero divisor needs no special path, every trial passes and opa lands in acc
  always_ff @(posedge clk_i) begin
    if (load_i) begin
      op_q  <= op_i;
      dvs_q <= opb_i;
      dz_q  <= (op_i == divsqrt_pkg::OP_DIV) && (opb_i == '0);
    end
    if (step_en) begin
      acc_q <= bit_ok ? diff[OW-1:0] : r_shift[OW-1:0];  // Restore on fail
      res_q <= {cur_res[OW-2:0], bit_ok};
      sh_q  <= (cur_op == divsqrt_pkg::OP_DIV) ? cur_sh << 1 : cur_sh << 2;
    end
  end

  // ----------------------------------------
  // Step counter and done
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q  <= '0;
      done_q <= 1'b0;
    end else if (load_i) begin
      cnt_q  <= (op_i == divsqrt_pkg::OP_DIV) ? DIV_LAST : SQRT_LAST;
      done_q <= 1'b0;  // Restart drops a pending done
    end else begin
      if (cnt_q != '0) cnt_q <= cnt_q - step_cnt_t'(1);
      done_q <= (cnt_q == step_cnt_t'(1));  // Last step runs now
    end
  end

  assign done_o     = done_q;
  assign res.result = res_q;
  assign res.rem    = acc_q;
  assign res.dz     = dz_q;

  a_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    done_o |=> !done_o);

endmodule

// ==== verilog/divsqrt_issue_stage.sv ====
// Single input register; flush drops the held item and any item accepted in the same cycle
`timescale 1ns/1ps

module divsqrt_issue_stage (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  input  divsqrt_pkg::op_e      in_op_i,
  input  divsqrt_pkg::operand_t in_opa_i,
  input  divsqrt_pkg::operand_t in_opb_i,
  input  divsqrt_pkg::tag_t     in_tag_i,
  input  logic                  flush_i,
  op_if.producer                op,
  output logic                  busy_o
);

  logic valid_q;  // Stage holds an operation
  logic reg_en;   // Load the payload registers

  // Advance when empty or when the engine takes the current item
  assign in_ready_o = ~valid_q | op.ready;
  assign reg_en     = in_valid_i & in_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;  // Cancel what is waiting here
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;  // Bubble when nothing arrives
    end
  end

  // Payload, enable register only
  always_ff @(posedge clk_i) begin
    if (reg_en) begin
      op.op  <= in_op_i;
      op.opa <= in_opa_i;
      op.opb <= in_opb_i;
      op.tag <= in_tag_i;
    end
  end

  assign op.valid = valid_q;
  assign busy_o   = valid_q;

  // A stalled item stays put until the engine takes it
  a_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    op.valid && !op.ready && !flush_i |=>
      op.valid && $stable({op.op, op.opa, op.opb, op.tag}));

endmodule

// ==== verilog/divsqrt_if.sv ====
// Plain signal bundles without clock; the handshake rules live in the modules that use them
`timescale 1ns/1ps

// ----------------------------------------
// Operation bus, issue stage to engine
// ----------------------------------------
interface op_if;
  logic                  valid;  // Operation present
  logic                  ready;  // Engine idle and able to take it
  divsqrt_pkg::op_e      op;
  divsqrt_pkg::operand_t opa;    // Dividend or radicand
  divsqrt_pkg::operand_t opb;    // Divisor, ignored for square root
  divsqrt_pkg::tag_t     tag;

  modport producer (output valid, op, opa, opb, tag, input ready);
  modport consumer (input valid, op, opa, opb, tag, output ready);
endinterface

// ----------------------------------------
// Result bus, engine to output stage
// ----------------------------------------
interface res_if;
  logic                  valid;   // From the control FSM
  logic                  ready;   // From the output stage
  divsqrt_pkg::operand_t result;  // Quotient or root
  divsqrt_pkg::operand_t rem;     // Remainder of either operation
  logic                  dz;      // Divide by zero seen
  divsqrt_pkg::tag_t     tag;

  // Engine side is split, handshake and tag from ctrl, payload from datapath
  modport producer_ctl (output valid, tag, input ready);
  modport producer_dp (output result, rem, dz);
  modport consumer (input valid, result, rem, dz, tag, output ready);
endinterface

// ==== verilog/divsqrt_pkg.sv ====
// Widths are fixed here; the modules are written for a 32-bit operand and a 4-bit tag only
package divsqrt_pkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------
  localparam int unsigned OPERAND_W = 32;  // Dividend, divisor and radicand width
  localparam int unsigned TAG_W     = 4;   // Caller's tag width

  // ----------------------------------------
  // Types
  // ----------------------------------------
  typedef logic [OPERAND_W-1:0] operand_t;  // Any operand, quotient, root or remainder
  typedef logic [TAG_W-1:0]     tag_t;      // Passed through untouched

  typedef enum logic {
    OP_DIV  = 1'b0,  // Unsigned integer divide
    OP_SQRT = 1'b1   // Integer square root of opa
  } op_e;

  // Iterations per operation, one result bit each
  localparam int unsigned DIV_STEPS  = 32;
  localparam int unsigned SQRT_STEPS = 16;  // Two radicand bits per root bit

endpackage
